//--- logic/snf_qos_pkg.sv
//******************************
// pool sizes must add up to mshr_entries
// lowest_set takes vectors up to mshr_entries wide
//******************************
package snf_qos_pkg;

    // tracker slots
    localparam int mshr_entries = 8;
    localparam int mshr_idx_w = 3;

    // request and response fields
    localparam int srcid_w = 7;
    localparam int txnid_w = 8;
    localparam int qos_w = 4;
    localparam int pcrdtype_w = 4;

    // qos split and pool sizes
    localparam int qos_high_min = 8;
    localparam int high_pool_num = 4;
    localparam int low_pool_num = 4;
    localparam int pool_cnt_w = 3;

    // pool owning a slot
    localparam int class_w = 2;
    localparam logic [class_w-1:0] class_low = 2'd1;
    localparam logic [class_w-1:0] class_high = 2'd2;

    // retry bank
    localparam int ret_bank_entries = 4;
    localparam int ret_bank_idx_w = 2;
    localparam int ret_cnt_w = 4;

    // response queues
    localparam int retryack_w = srcid_w + txnid_w + qos_w + pcrdtype_w;
    localparam int pcrdgnt_w = srcid_w + qos_w + pcrdtype_w;
    localparam int retryack_depth = 4;
    localparam int pcrdgnt_depth = 4;
    // fill count, wide enough for depth 4
    localparam int q_cnt_w = 3;

    // index of the lowest set bit, zero when none
    function automatic logic [mshr_idx_w-1:0] lowest_set(input logic [mshr_entries-1:0] vec);
        logic [mshr_idx_w-1:0] idx;
        idx = '0;
        for (int i = mshr_entries - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = mshr_idx_w'(i);
            end
        end
        return idx;
    endfunction

endpackage

//--- logic/rsp_fifo.sv
`timescale 1ns/1ns
//******************************
// depth must be a power of two
//******************************
module rsp_fifo #(
    parameter int width = 8,
    parameter int depth = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [width-1:0] push_data,
    input  logic             pop_won,
    output logic [width-1:0] head_data,
    output logic             not_empty
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] cnt_q;
    logic             full;
    logic             push_ok;
    logic             pop_ok;

    assign not_empty = cnt_q != '0;
    assign full = cnt_q == cnt_w'(depth);
    // full queue still accepts when popped in the same cycle
    assign push_ok = push & (~full | pop_won);
    assign pop_ok = pop_won & not_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + ptr_w'(1);
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + ptr_w'(1);
            end
            cnt_q <= cnt_q + cnt_w'(push_ok) - cnt_w'(pop_ok);
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

    assign head_data = mem[rd_ptr_q];

endmodule

//--- logic/qos_admit.sv
`timescale 1ns/1ns
//******************************
// static requests bypass the pools
// RetryAck fill level is tracked here to gate the push
//******************************
module qos_admit
    import snf_qos_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  logic [srcid_w-1:0]    req_srcid,
    input  logic [txnid_w-1:0]    req_txnid,
    input  logic [qos_w-1:0]      req_qos,
    input  logic                  req_allowretry,
    input  logic                  retire_valid,
    input  logic [class_w-1:0]    retire_class,
    input  logic                  reserve_slot,
    input  logic                  retryack_won,
    output logic                  alloc_en,
    output logic                  alloc_static,
    output logic [class_w-1:0]    alloc_pool_class,
    output logic                  retry_en,
    output logic                  req_high,
    output logic                  retryack_push,
    output logic [retryack_w-1:0] retryack_word
);

    logic                  req_dyn;
    logic                  req_static;
    logic                  take_high;
    logic                  take_low;
    logic                  high_inc;
    logic                  high_dec;
    logic                  low_inc;
    logic                  low_dec;
    logic [pool_cnt_w-1:0] high_cnt_q;
    logic [pool_cnt_w-1:0] low_cnt_q;
    logic [pool_cnt_w-1:0] high_cnt_next;
    logic [pool_cnt_w-1:0] low_cnt_next;
    logic                  high_full_q;
    logic                  low_full_q;
    logic [q_cnt_w-1:0]    ra_cnt_q;
    logic                  ra_full;
    logic                  ra_pop;

    assign req_high = req_qos >= qos_w'(qos_high_min);
    assign req_dyn = req_valid & req_allowretry;
    assign req_static = req_valid & ~req_allowretry;

    // high tries its own pool first, then spills to low
    assign take_high = req_high & ~high_full_q;
    assign take_low = ~take_high & ~low_full_q;

    assign alloc_en = req_static | (req_dyn & (take_high | take_low));
    assign alloc_static = req_static;
    assign alloc_pool_class = take_high ? class_high : class_low;
    assign retry_en = req_dyn & ~take_high & ~take_low;

    // a reserved retire hands the slot on, so the pool stays charged
    assign high_inc = req_dyn & take_high;
    assign high_dec = retire_valid & ~reserve_slot & (retire_class == class_high);
    assign low_inc = req_dyn & take_low;
    assign low_dec = retire_valid & ~reserve_slot & (retire_class == class_low);

    assign high_cnt_next = high_cnt_q + pool_cnt_w'(high_inc) - pool_cnt_w'(high_dec);
    assign low_cnt_next = low_cnt_q + pool_cnt_w'(low_inc) - pool_cnt_w'(low_dec);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            high_cnt_q <= '0;
            low_cnt_q <= '0;
            high_full_q <= 1'b0;
            low_full_q <= 1'b0;
        end else begin
            high_cnt_q <= high_cnt_next;
            low_cnt_q <= low_cnt_next;
            high_full_q <= high_cnt_next == pool_cnt_w'(high_pool_num);
            low_full_q <= low_cnt_next == pool_cnt_w'(low_pool_num);
        end
    end

    // pcrdtype bit 1 high, bit 0 low
    assign retryack_word = {req_srcid, req_txnid, req_qos, pcrdtype_w'({req_high, ~req_high})};

    assign ra_full = ra_cnt_q == q_cnt_w'(retryack_depth);
    assign ra_pop = retryack_won & (ra_cnt_q != '0);
    assign retryack_push = retry_en & (~ra_full | retryack_won);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ra_cnt_q <= '0;
        end else begin
            ra_cnt_q <= ra_cnt_q + q_cnt_w'(retryack_push) - q_cnt_w'(ra_pop);
        end
    end

endmodule

//--- logic/mshr_slot_alloc.sv
`timescale 1ns/1ns
//******************************
// retire_idx must name a busy slot
//******************************
module mshr_slot_alloc
    import snf_qos_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc_en,
    input  logic                  alloc_static,
    input  logic [class_w-1:0]    alloc_pool_class,
    input  logic                  retire_valid,
    input  logic [mshr_idx_w-1:0] retire_idx,
    input  logic                  reserve_slot,
    output logic [mshr_idx_w-1:0] alloc_idx,
    output logic [class_w-1:0]    retire_class
);

    logic [mshr_entries-1:0] busy_q;
    logic [mshr_entries-1:0] rsvd_q;
    logic [mshr_entries-1:0] alloc_vec;
    logic [mshr_entries-1:0] alloc_vec_q;
    logic [mshr_entries-1:0] retire_vec;
    logic [class_w-1:0]      pool_q [mshr_entries];

    // static takes a reserved slot, dynamic a clean one
    assign alloc_idx = alloc_static ? lowest_set(rsvd_q & ~busy_q)
                                    : lowest_set(~rsvd_q & ~busy_q);

    always_comb begin
        for (int i = 0; i < mshr_entries; i++) begin
            alloc_vec[i] = alloc_en && (alloc_idx == mshr_idx_w'(i));
            retire_vec[i] = retire_valid && (retire_idx == mshr_idx_w'(i));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= '0;
            rsvd_q <= '0;
            alloc_vec_q <= '0;
        end else begin
            busy_q <= (busy_q & ~retire_vec) | alloc_vec;
            alloc_vec_q <= alloc_vec;
            // reservation drops one cycle after the slot is taken
            rsvd_q <= (rsvd_q & ~alloc_vec_q) | (retire_vec & {mshr_entries{reserve_slot}});
        end
    end

    // reserved slots keep the class from their dynamic owner
    always_ff @(posedge clk) begin
        for (int i = 0; i < mshr_entries; i++) begin
            if (alloc_vec[i] && !alloc_static) begin
                pool_q[i] <= alloc_pool_class;
            end
        end
    end

    assign retire_class = pool_q[retire_idx];

endmodule

//--- logic/retry_bank.sv
`timescale 1ns/1ns
//******************************
// a new source overwrites the round-robin entry with its counts
// a grant dropped on a full queue is lost
//******************************
module retry_bank
    import snf_qos_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [srcid_w-1:0]   req_srcid,
    input  logic                 retry_en,
    input  logic                 req_high,
    input  logic                 retire_valid,
    input  logic [class_w-1:0]   retire_class,
    input  logic                 pcrdgnt_won,
    output logic                 reserve_slot,
    output logic                 pcrdgnt_push,
    output logic [pcrdgnt_w-1:0] pcrdgnt_word
);

    logic [srcid_w-1:0]          srcid_q [ret_bank_entries];
    logic [ret_bank_entries-1:0] valid_q;
    logic [ret_bank_idx_w-1:0]   wr_ptr_q;
    logic [ret_cnt_w-1:0]        cnt_h_q [ret_bank_entries];
    logic [ret_cnt_w-1:0]        cnt_l_q [ret_bank_entries];
    logic [ret_cnt_w-1:0]        cnt_h_next [ret_bank_entries];
    logic [ret_cnt_w-1:0]        cnt_l_next [ret_bank_entries];
    logic [ret_bank_entries-1:0] match;
    logic [ret_bank_entries-1:0] inc_sel;
    logic [ret_bank_entries-1:0] inc_h;
    logic [ret_bank_entries-1:0] inc_l;
    logic [ret_bank_entries-1:0] dec_h;
    logic [ret_bank_entries-1:0] dec_l;
    logic [ret_bank_entries-1:0] h_wait;
    logic [ret_bank_entries-1:0] l_wait;
    logic                        new_entry;
    logic                        gnt_h;
    logic                        gnt_l;
    logic                        gnt_h_q;
    logic                        gnt_l_q;
    logic [ret_bank_idx_w-1:0]   gnt_sel_q;
    logic [q_cnt_w-1:0]          pg_cnt_q;
    logic                        pg_full;
    logic                        pg_pop;

    always_comb begin
        for (int i = 0; i < ret_bank_entries; i++) begin
            match[i] = valid_q[i] && (srcid_q[i] == req_srcid);
        end
    end

    assign new_entry = retry_en & ~(|match);

    // counts after this cycle's retry and pending grant
    always_comb begin
        for (int i = 0; i < ret_bank_entries; i++) begin
            inc_sel[i] = new_entry ? (wr_ptr_q == ret_bank_idx_w'(i)) : match[i];
            inc_h[i] = retry_en & req_high & inc_sel[i];
            inc_l[i] = retry_en & ~req_high & inc_sel[i];
            dec_h[i] = gnt_h_q & pcrdgnt_push & (gnt_sel_q == ret_bank_idx_w'(i));
            dec_l[i] = gnt_l_q & pcrdgnt_push & (gnt_sel_q == ret_bank_idx_w'(i));
            // an overwritten entry starts again from zero
            cnt_h_next[i] = (new_entry & inc_sel[i]) ? ret_cnt_w'(inc_h[i])
                            : cnt_h_q[i] + ret_cnt_w'(inc_h[i]) - ret_cnt_w'(dec_h[i]);
            cnt_l_next[i] = (new_entry & inc_sel[i]) ? ret_cnt_w'(inc_l[i])
                            : cnt_l_q[i] + ret_cnt_w'(inc_l[i]) - ret_cnt_w'(dec_l[i]);
            h_wait[i] = cnt_h_next[i] != '0;
            l_wait[i] = cnt_l_next[i] != '0;
        end
    end

    // high waiters always win, low only on a low-pool retire
    assign gnt_h = retire_valid & (|h_wait);
    assign gnt_l = retire_valid & ~(|h_wait) & (|l_wait) & (retire_class == class_low);
    assign reserve_slot = gnt_h | gnt_l;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            wr_ptr_q <= '0;
            gnt_h_q <= 1'b0;
            gnt_l_q <= 1'b0;
            pg_cnt_q <= '0;
            for (int i = 0; i < ret_bank_entries; i++) begin
                cnt_h_q[i] <= '0;
                cnt_l_q[i] <= '0;
            end
        end else begin
            if (new_entry) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q <= wr_ptr_q + ret_bank_idx_w'(1);
            end
            for (int i = 0; i < ret_bank_entries; i++) begin
                cnt_h_q[i] <= cnt_h_next[i];
                cnt_l_q[i] <= cnt_l_next[i];
            end
            gnt_h_q <= gnt_h;
            gnt_l_q <= gnt_l;
            pg_cnt_q <= pg_cnt_q + q_cnt_w'(pcrdgnt_push) - q_cnt_w'(pg_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (new_entry) begin
            srcid_q[wr_ptr_q] <= req_srcid;
        end
        if (reserve_slot) begin
            gnt_sel_q <= ret_bank_idx_w'(lowest_set(mshr_entries'(gnt_h ? h_wait : l_wait)));
        end
    end

    assign pg_full = pg_cnt_q == q_cnt_w'(pcrdgnt_depth);
    assign pg_pop = pcrdgnt_won & (pg_cnt_q != '0);
    assign pcrdgnt_push = (gnt_h_q | gnt_l_q) & (~pg_full | pcrdgnt_won);

    // high grant carries qos 0xf, low grant qos 0
    assign pcrdgnt_word = {srcid_q[gnt_sel_q], {qos_w{gnt_h_q}},
                           pcrdtype_w'({gnt_h_q, gnt_l_q})};

endmodule

//--- logic/snf_qos.sv
`timescale 1ns/1ns
//******************************
// queue heads are valid only while the valid output is high
//******************************
module snf_qos
    import snf_qos_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  logic [srcid_w-1:0]    req_srcid,
    input  logic [txnid_w-1:0]    req_txnid,
    input  logic [qos_w-1:0]      req_qos,
    input  logic                  req_allowretry,
    input  logic                  retire_valid,
    input  logic [mshr_idx_w-1:0] retire_idx,
    input  logic                  retryack_won,
    input  logic                  pcrdgnt_won,
    output logic                  alloc_en,
    output logic [mshr_idx_w-1:0] alloc_idx,
    output logic                  retry_en,
    output logic                  retryack_valid,
    output logic [srcid_w-1:0]    retryack_srcid,
    output logic [txnid_w-1:0]    retryack_txnid,
    output logic [qos_w-1:0]      retryack_qos,
    output logic [pcrdtype_w-1:0] retryack_pcrdtype,
    output logic                  pcrdgnt_valid,
    output logic [srcid_w-1:0]    pcrdgnt_srcid,
    output logic [qos_w-1:0]      pcrdgnt_qos,
    output logic [pcrdtype_w-1:0] pcrdgnt_pcrdtype
);

    logic                  alloc_static;
    logic [class_w-1:0]    alloc_pool_class;
    logic [class_w-1:0]    retire_class;
    logic                  reserve_slot;
    logic                  req_high;
    logic                  retryack_push;
    logic [retryack_w-1:0] retryack_word;
    logic [retryack_w-1:0] retryack_head;
    logic                  pcrdgnt_push;
    logic [pcrdgnt_w-1:0]  pcrdgnt_word;
    logic [pcrdgnt_w-1:0]  pcrdgnt_head;

    qos_admit qos_admit_i (
        .clk              (clk),
        .rst              (rst),
        .req_valid        (req_valid),
        .req_srcid        (req_srcid),
        .req_txnid        (req_txnid),
        .req_qos          (req_qos),
        .req_allowretry   (req_allowretry),
        .retire_valid     (retire_valid),
        .retire_class     (retire_class),
        .reserve_slot     (reserve_slot),
        .retryack_won     (retryack_won),
        .alloc_en         (alloc_en),
        .alloc_static     (alloc_static),
        .alloc_pool_class (alloc_pool_class),
        .retry_en         (retry_en),
        .req_high         (req_high),
        .retryack_push    (retryack_push),
        .retryack_word    (retryack_word)
    );

    mshr_slot_alloc mshr_slot_alloc_i (
        .clk              (clk),
        .rst              (rst),
        .alloc_en         (alloc_en),
        .alloc_static     (alloc_static),
        .alloc_pool_class (alloc_pool_class),
        .retire_valid     (retire_valid),
        .retire_idx       (retire_idx),
        .reserve_slot     (reserve_slot),
        .alloc_idx        (alloc_idx),
        .retire_class     (retire_class)
    );

    retry_bank retry_bank_i (
        .clk          (clk),
        .rst          (rst),
        .req_srcid    (req_srcid),
        .retry_en     (retry_en),
        .req_high     (req_high),
        .retire_valid (retire_valid),
        .retire_class (retire_class),
        .pcrdgnt_won  (pcrdgnt_won),
        .reserve_slot (reserve_slot),
        .pcrdgnt_push (pcrdgnt_push),
        .pcrdgnt_word (pcrdgnt_word)
    );

    rsp_fifo #(
        .width (retryack_w),
        .depth (retryack_depth)
    ) retryack_q (
        .clk       (clk),
        .rst       (rst),
        .push      (retryack_push),
        .push_data (retryack_word),
        .pop_won   (retryack_won),
        .head_data (retryack_head),
        .not_empty (retryack_valid)
    );

    rsp_fifo #(
        .width (pcrdgnt_w),
        .depth (pcrdgnt_depth)
    ) pcrdgnt_q (
        .clk       (clk),
        .rst       (rst),
        .push      (pcrdgnt_push),
        .push_data (pcrdgnt_word),
        .pop_won   (pcrdgnt_won),
        .head_data (pcrdgnt_head),
        .not_empty (pcrdgnt_valid)
    );

    assign {retryack_srcid, retryack_txnid, retryack_qos, retryack_pcrdtype} = retryack_head;
    assign {pcrdgnt_srcid, pcrdgnt_qos, pcrdgnt_pcrdtype} = pcrdgnt_head;

endmodule

//--- tests/snf_qos_tb.sv
`timescale 1ns/1ns
//******************************
// steps come from tests/snf_qos_cases.txt, run from the project root
// wait lines repeat their inputs every cycle, so keep them idle
//******************************
module snf_qos_tb
    import snf_qos_pkg::*;
();

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    logic [srcid_w-1:0]    req_srcid;
    logic [txnid_w-1:0]    req_txnid;
    logic [qos_w-1:0]      req_qos;
    logic                  req_allowretry;
    logic                  retire_valid;
    logic [mshr_idx_w-1:0] retire_idx;
    logic                  retryack_won;
    logic                  pcrdgnt_won;
    logic                  alloc_en;
    logic [mshr_idx_w-1:0] alloc_idx;
    logic                  retry_en;
    logic                  retryack_valid;
    logic [srcid_w-1:0]    retryack_srcid;
    logic [txnid_w-1:0]    retryack_txnid;
    logic [qos_w-1:0]      retryack_qos;
    logic [pcrdtype_w-1:0] retryack_pcrdtype;
    logic                  pcrdgnt_valid;
    logic [srcid_w-1:0]    pcrdgnt_srcid;
    logic [qos_w-1:0]      pcrdgnt_qos;
    logic [pcrdtype_w-1:0] pcrdgnt_pcrdtype;

    string tok [32];
    string line;
    int    ntok;
    int    nread;
    int    fd;
    int    line_no;
    int    cur_test;
    int    test_checks;
    int    test_errors;
    int    tests_run;
    int    tests_bad;
    int    checks;
    int    errors;

    snf_qos snf_qos_i (
        .clk               (clk),
        .rst               (rst),
        .req_valid         (req_valid),
        .req_srcid         (req_srcid),
        .req_txnid         (req_txnid),
        .req_qos           (req_qos),
        .req_allowretry    (req_allowretry),
        .retire_valid      (retire_valid),
        .retire_idx        (retire_idx),
        .retryack_won      (retryack_won),
        .pcrdgnt_won       (pcrdgnt_won),
        .alloc_en          (alloc_en),
        .alloc_idx         (alloc_idx),
        .retry_en          (retry_en),
        .retryack_valid    (retryack_valid),
        .retryack_srcid    (retryack_srcid),
        .retryack_txnid    (retryack_txnid),
        .retryack_qos      (retryack_qos),
        .retryack_pcrdtype (retryack_pcrdtype),
        .pcrdgnt_valid     (pcrdgnt_valid),
        .pcrdgnt_srcid     (pcrdgnt_srcid),
        .pcrdgnt_qos       (pcrdgnt_qos),
        .pcrdgnt_pcrdtype  (pcrdgnt_pcrdtype)
    );

    always #10 clk = ~clk;

    // whitespace separated fields, '#' starts a comment
    task automatic split_line(input string s);
        logic [7:0] c;
        int         start;
        logic       done;
        ntok = 0;
        start = -1;
        done = 1'b0;
        for (int i = 0; i <= s.len() && !done; i++) begin
            c = (i < s.len()) ? s.getc(i) : 8'h20;
            if (c == 8'h23) begin
                done = 1'b1;
                c = 8'h20;
            end
            if (c == 8'h20 || c == 8'h09 || c == 8'h0a || c == 8'h0d) begin
                if (start >= 0 && ntok < 32) begin
                    tok[ntok] = s.substr(start, i - 1);
                    ntok++;
                end
                start = -1;
            end else if (start < 0) begin
                start = i;
            end
        end
    endtask

    function automatic logic [31:0] hex_value(input string s);
        return 32'(s.atohex());
    endfunction

    // a field of dashes is a don't care
    task automatic check_value(input string name, input logic [31:0] got, input string exp);
        logic [31:0] want;
        if (exp.getc(0) != 8'h2d) begin
            want = hex_value(exp);
            checks++;
            test_checks++;
            if (got !== want) begin
                $display("Fail %s: got %0h, expected %0h (line %0d)", name, got, want, line_no);
                errors++;
                test_errors++;
            end
        end
    endtask

    task automatic drive_inputs();
        req_valid = 1'(hex_value(tok[2]));
        req_srcid = srcid_w'(hex_value(tok[3]));
        req_txnid = txnid_w'(hex_value(tok[4]));
        req_qos = qos_w'(hex_value(tok[5]));
        req_allowretry = 1'(hex_value(tok[6]));
        retire_valid = 1'(hex_value(tok[7]));
        retire_idx = mshr_idx_w'(hex_value(tok[8]));
        retryack_won = 1'(hex_value(tok[9]));
        pcrdgnt_won = 1'(hex_value(tok[10]));
    endtask

    task automatic compare_outputs();
        check_value("alloc_en", 32'(alloc_en), tok[11]);
        check_value("alloc_idx", 32'(alloc_idx), tok[12]);
        check_value("retry_en", 32'(retry_en), tok[13]);
        check_value("retryack_valid", 32'(retryack_valid), tok[14]);
        check_value("retryack_srcid", 32'(retryack_srcid), tok[15]);
        check_value("retryack_txnid", 32'(retryack_txnid), tok[16]);
        check_value("retryack_qos", 32'(retryack_qos), tok[17]);
        check_value("retryack_pcrdtype", 32'(retryack_pcrdtype), tok[18]);
        check_value("pcrdgnt_valid", 32'(pcrdgnt_valid), tok[19]);
        check_value("pcrdgnt_srcid", 32'(pcrdgnt_srcid), tok[20]);
        check_value("pcrdgnt_qos", 32'(pcrdgnt_qos), tok[21]);
        check_value("pcrdgnt_pcrdtype", 32'(pcrdgnt_pcrdtype), tok[22]);
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d done: %0d checks, no errors", cur_test, test_checks);
        end else begin
            tests_bad++;
            $display("test %0d done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        end
    endtask

    // one cycle: drive 2 ns after the edge, sample 2 ns before the next
    task automatic one_cycle();
        @(posedge clk);
        #2;
        drive_inputs();
        #16;
    endtask

    task automatic wait_valid(input logic on_retryack);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 20) begin
            one_cycle();
            seen = on_retryack ? retryack_valid : pcrdgnt_valid;
            cycles++;
        end
        if (seen) begin
            compare_outputs();
        end else begin
            $display("timeout: %s stayed low for 20 cycles in test %0d",
                     on_retryack ? "retryack_valid" : "pcrdgnt_valid", cur_test);
            errors++;
            test_errors++;
        end
    endtask

    task automatic run_step();
        int tn;
        tn = tok[0].atoi();
        if (tn != cur_test) begin
            if (cur_test >= 0) begin
                end_test();
            end
            cur_test = tn;
            test_checks = 0;
            test_errors = 0;
        end
        if (tok[1] == "s") begin
            one_cycle();
            compare_outputs();
        end else if (tok[1] == "wr" || tok[1] == "wp") begin
            wait_valid(tok[1] == "wr");
        end else begin
            $display("line %0d has an unknown step kind %s", line_no, tok[1]);
            errors++;
            test_errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_srcid = '0;
        req_txnid = '0;
        req_qos = '0;
        req_allowretry = 1'b0;
        retire_valid = 1'b0;
        retire_idx = '0;
        retryack_won = 1'b0;
        pcrdgnt_won = 1'b0;
        line_no = 0;
        cur_test = -1;
        tests_run = 0;
        tests_bad = 0;
        checks = 0;
        errors = 0;
        fd = $fopen("tests/snf_qos_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/snf_qos_cases.txt");
            $display("tests failed");
        end else begin
            repeat (5) @(posedge clk);
            #2;
            rst = 1'b0;
            while ($feof(fd) == 0) begin
                line = "";
                nread = $fgets(line, fd);
                if (nread > 0) begin
                    line_no++;
                    split_line(line);
                    if (ntok == 23) begin
                        run_step();
                    end else if (ntok != 0) begin
                        $display("line %0d has %0d fields instead of 23", line_no, ntok);
                        errors++;
                    end
                end
            end
            $fclose(fd);
            if (cur_test >= 0) begin
                end_test();
            end
            $display("%0d tests run, %0d with errors, %0d checks, %0d errors",
                     tests_run, tests_bad, checks, errors);
            if (errors == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
        end
        $finish;
    end

endmodule

//--- tests/snf_qos_cases.txt
# test kind(s step, wr/wp wait for retryack/pcrdgnt valid) | rv srcid txnid qos allowretry
# retv retidx rawon pgwon | alloc_en idx retry_en | ra: v src txn qos type | pg: v src qos type
1 s  0 00 00 0 0  0 0 0 0   0 - 0  0 -- -- - -  0 -- - -
1 s  1 01 10 2 1  0 0 0 0   1 0 0  0 -- -- - -  0 -- - -
1 s  1 02 11 2 1  0 0 0 0   1 1 0  0 -- -- - -  0 -- - -
1 s  1 03 12 3 1  0 0 0 0   1 2 0  0 -- -- - -  0 -- - -
2 s  1 04 13 1 1  0 0 0 0   1 3 0  0 -- -- - -  0 -- - -
2 s  1 05 14 2 1  0 0 0 0   0 - 1  0 -- -- - -  0 -- - -
2 wr 0 00 00 0 0  0 0 0 0   0 - 0  1 05 14 2 1  0 -- - -
2 s  0 00 00 0 0  0 0 1 0   0 - 0  1 05 14 2 1  0 -- - -
2 s  1 06 20 8 1  0 0 0 0   1 4 0  0 -- -- - -  0 -- - -
2 s  1 07 21 c 1  0 0 0 0   1 5 0  0 -- -- - -  0 -- - -
2 s  1 08 22 f 1  0 0 0 0   1 6 0  0 -- -- - -  0 -- - -
2 s  1 09 23 9 1  0 0 0 0   1 7 0  0 -- -- - -  0 -- - -
2 s  1 0a 24 a 1  0 0 0 0   0 - 1  0 -- -- - -  0 -- - -
2 wr 0 00 00 0 0  0 0 0 0   0 - 0  1 0a 24 a 2  0 -- - -
2 s  0 00 00 0 0  0 0 1 0   0 - 0  1 0a 24 a 2  0 -- - -
3 s  0 00 00 0 0  1 0 0 0   0 - 0  0 -- -- - -  0 -- - -
3 wp 0 00 00 0 0  0 0 0 0   0 - 0  0 -- -- - -  1 0a f 2
3 s  0 00 00 0 0  0 0 0 1   0 - 0  0 -- -- - -  1 0a f 2
3 s  1 0a 25 a 0  0 0 0 0   1 0 0  0 -- -- - -  0 -- - -
3 s  1 0b 26 e 1  0 0 0 0   0 - 1  0 -- -- - -  0 -- - -
3 wr 0 00 00 0 0  0 0 0 0   0 - 0  1 0b 26 e 2  0 -- - -
3 s  0 00 00 0 0  0 0 1 0   0 - 0  1 0b 26 e 2  0 -- - -
3 s  0 00 00 0 0  1 4 0 0   0 - 0  0 -- -- - -  0 -- - -
3 wp 0 00 00 0 0  0 0 0 0   0 - 0  0 -- -- - -  1 0b f 2
3 s  0 00 00 0 0  0 0 0 1   0 - 0  0 -- -- - -  1 0b f 2
3 s  1 0b 27 e 0  0 0 0 0   1 4 0  0 -- -- - -  0 -- - -
4 s  0 00 00 0 0  1 5 0 0   0 - 0  0 -- -- - -  0 -- - -
4 s  1 0c 30 8 1  0 0 0 0   1 5 0  0 -- -- - -  0 -- - -
4 s  0 00 00 0 0  1 1 0 0   0 - 0  0 -- -- - -  0 -- - -
4 wp 0 00 00 0 0  0 0 0 0   0 - 0  0 -- -- - -  1 05 0 1
4 s  0 00 00 0 0  0 0 0 1   0 - 0  0 -- -- - -  1 05 0 1
4 s  1 05 31 2 0  0 0 0 0   1 1 0  0 -- -- - -  0 -- - -
5 s  1 13 40 1 1  0 0 0 0   0 - 1  0 -- -- - -  0 -- - -
5 s  1 14 41 9 1  0 0 0 0   0 - 1  1 13 40 1 1  0 -- - -
5 s  1 15 42 3 1  0 0 0 0   0 - 1  1 13 40 1 1  0 -- - -
5 s  0 00 00 0 0  0 0 0 0   0 - 0  1 13 40 1 1  0 -- - -
5 s  1 16 43 c 1  0 0 0 0   0 - 1  1 13 40 1 1  0 -- - -
5 s  1 17 44 0 1  0 0 0 0   0 - 1  1 13 40 1 1  0 -- - -
5 s  0 00 00 0 0  0 0 1 0   0 - 0  1 13 40 1 1  0 -- - -
5 s  0 00 00 0 0  0 0 1 0   0 - 0  1 14 41 9 2  0 -- - -
5 s  0 00 00 0 0  0 0 1 0   0 - 0  1 15 42 3 1  0 -- - -
5 s  0 00 00 0 0  0 0 1 0   0 - 0  1 16 43 c 2  0 -- - -
5 s  0 00 00 0 0  0 0 0 0   0 - 0  0 -- -- - -  0 -- - -

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run from the project root, then search the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module snf_qos_tb \
    -Mdir obj_dir -o snf_qos_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/snf_qos_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^all tests passed$" sim.log; then
    exit 0
else
    exit 1
fi

//--- filelist.f
logic/snf_qos_pkg.sv
logic/rsp_fifo.sv
logic/qos_admit.sv
logic/mshr_slot_alloc.sv
logic/retry_bank.sv
logic/snf_qos.sv
tests/snf_qos_tb.sv
